/* branch_predictor.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module branch_predictor import fetch_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  addr_t                    pc_start,
    input  logic                     resolve_valid,
    input  addr_t                    resolve_pc,
    input  logic                     resolve_taken,
    input  addr_t                    resolve_target,
    output logic [`FETCH_WIDTH-1:0]  lane_valid,
    output logic [`FETCH_WIDTH-1:0]  lane_taken,
    output addr_t [`FETCH_WIDTH-1:0] lane_next_pc
);

    // btb storage, direct mapped with a full address tag
    logic [`BTB_ENTRIES-1:0] btb_valid;
    addr_t                   btb_tag    [`BTB_ENTRIES];
    addr_t                   btb_target [`BTB_ENTRIES];

    addr_t                       lane_pc    [`FETCH_WIDTH];
    logic [`BTB_INDEX_BITS-1:0]  lane_index [`FETCH_WIDTH];
    logic [`BTB_INDEX_BITS-1:0]  resolve_index;
    logic                        earlier_taken;
    logic                        resolve_tag_match;

    // lookup per lane
    always_comb begin
        earlier_taken = 1'b0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane_pc[i]    = pc_start + addr_t'(4 * i);
            lane_index[i] = lane_pc[i][2 +: `BTB_INDEX_BITS];
            lane_taken[i] = btb_valid[lane_index[i]] &&
                            (btb_tag[lane_index[i]] == lane_pc[i]);
            lane_next_pc[i] = lane_taken[i] ? btb_target[lane_index[i]]
                                            : lane_pc[i] + 32'd4;
            // bundle ends at the first predicted-taken lane
            lane_valid[i] = !earlier_taken;
            earlier_taken = earlier_taken | lane_taken[i];
        end
    end

    assign resolve_index     = resolve_pc[2 +: `BTB_INDEX_BITS];
    assign resolve_tag_match = btb_valid[resolve_index] &&
                               (btb_tag[resolve_index] == resolve_pc);

    // training from the resolve port
    always_ff @(posedge clock) begin
        if (reset) begin
            btb_valid <= '0;
        end else if (resolve_valid) begin
            if (resolve_taken) begin
                btb_valid[resolve_index] <= 1'b1;
            end else if (resolve_tag_match) begin
                // drop a branch that stopped being taken
                btb_valid[resolve_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (resolve_valid && resolve_taken) begin
            btb_tag[resolve_index]    <= resolve_pc;
            btb_target[resolve_index] <= resolve_target;
        end
    end

endmodule

/* fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// lanes in one fetch bundle
`define FETCH_WIDTH 2

// instruction cache geometry
// one 64-bit block per line, so two instructions per line
`define ICACHE_LINES 32
`define ICACHE_INDEX_BITS 5

// branch target buffer geometry
// indexed by word address bits above the byte offset
`define BTB_ENTRIES 16
`define BTB_INDEX_BITS 4

// addi x0, x0, 0
`define NOP_INST 32'h00000013

`endif

/* fetch_pkg.sv */
package fetch_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // memory transaction tag
    // zero means no transaction is in flight
    typedef logic [3:0] mem_tag_t;

    // command on the memory port
    // fetch only ever issues loads
    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } mem_command_t;

    // one memory block
    // seen by memory and fills as a double word,
    // seen by the fetch stage as two instructions picked by address bit 2
    typedef union packed {
        logic [63:0]      double_word;
        inst_t [1:0]      insts;
    } mem_block_t;

endpackage

/* icache.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module icache import fetch_pkg::*; (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          stall,
    input  addr_t [`FETCH_WIDTH-1:0]      lookup_addr,
    input  logic [`FETCH_WIDTH-1:0]       lookup_valid,
    input  mem_tag_t                      mem_transaction_tag,
    input  mem_block_t                    mem_data,
    input  mem_tag_t                      mem_data_tag,
    output logic [`FETCH_WIDTH-1:0]       lookup_hit,
    output mem_block_t [`FETCH_WIDTH-1:0] lookup_block,
    output mem_command_t                  mem_command,
    output addr_t                         mem_addr
);

    // 8-byte blocks
    localparam int OFFSET_BITS = 3;
    localparam int TAG_BITS    = 32 - `ICACHE_INDEX_BITS - OFFSET_BITS;

    // miss handling states
    localparam logic [1:0] MISS_IDLE    = 2'd0;
    localparam logic [1:0] MISS_REQUEST = 2'd1;
    localparam logic [1:0] MISS_WAIT    = 2'd2;

    mem_block_t               cache_data [`ICACHE_LINES];
    logic [TAG_BITS-1:0]      cache_tag  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] cache_valid;

    logic [`ICACHE_INDEX_BITS-1:0] lane_index [`FETCH_WIDTH];
    logic [TAG_BITS-1:0]           lane_tag   [`FETCH_WIDTH];

    logic [1:0]                    miss_state;
    logic [1:0]                    miss_state_next;
    mem_tag_t                      pending_tag;
    addr_t                         miss_addr;
    logic                          miss_found;
    addr_t                         miss_candidate;
    logic                          miss_start;
    logic [`ICACHE_INDEX_BITS-1:0] fill_index;
    logic [TAG_BITS-1:0]           fill_tag;
    logic                          fill_done;

    // one read port per lane
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane_index[i]   = lookup_addr[i][OFFSET_BITS +: `ICACHE_INDEX_BITS];
            lane_tag[i]     = lookup_addr[i][31 -: TAG_BITS];
            lookup_hit[i]   = lookup_valid[i] && cache_valid[lane_index[i]] &&
                              (cache_tag[lane_index[i]] == lane_tag[i]);
            lookup_block[i] = cache_data[lane_index[i]];
        end
    end

    // walked from the top so the lowest missing lane wins
    always_comb begin
        miss_found     = 1'b0;
        miss_candidate = '0;
        for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
            if (lookup_valid[i] && !lookup_hit[i]) begin
                miss_found     = 1'b1;
                miss_candidate = {lookup_addr[i][31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            end
        end
    end

    assign miss_start = (miss_state == MISS_IDLE) && miss_found && !stall;
    assign fill_index = miss_addr[OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign fill_tag   = miss_addr[31 -: TAG_BITS];

    // data for our load shows up with the matching tag
    assign fill_done = (miss_state == MISS_WAIT) && (mem_data_tag == pending_tag);

    always_comb begin
        miss_state_next = miss_state;
        case (miss_state)
            MISS_IDLE: begin
                if (miss_start) begin
                    miss_state_next = MISS_REQUEST;
                end
            end
            MISS_REQUEST: begin
                // a zero tag means the load was not taken, so send it again
                if (mem_transaction_tag != '0) begin
                    miss_state_next = MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (fill_done) begin
                    miss_state_next = MISS_IDLE;
                end
            end
            default: begin
                miss_state_next = MISS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            miss_state  <= MISS_IDLE;
            pending_tag <= '0;
            cache_valid <= '0;
        end else begin
            miss_state <= miss_state_next;
            if (miss_state == MISS_REQUEST) begin
                pending_tag <= mem_transaction_tag;
            end
            if (fill_done) begin
                cache_valid[fill_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (miss_start) begin
            miss_addr <= miss_candidate;
        end
        if (fill_done) begin
            cache_data[fill_index].double_word <= mem_data.double_word;
            cache_tag[fill_index]              <= fill_tag;
        end
    end

    // single-cycle load strobe
    assign mem_command = (miss_state == MISS_REQUEST) ? MEM_LOAD : MEM_NONE;
    assign mem_addr    = (miss_state == MISS_REQUEST) ? miss_addr : '0;

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    --top-module tb_stage_fetch -f vlog.f -o tb_stage_fetch

./obj_dir/tb_stage_fetch > sim.log
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

/* stage_fetch.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module stage_fetch import fetch_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     stall,

    // resolve port from the back end
    input  logic                     resolve_valid,
    input  addr_t                    resolve_pc,
    input  logic                     resolve_taken,
    input  addr_t                    resolve_target,
    input  logic                     resolve_mispredict,

    // memory side
    input  mem_tag_t                 mem_transaction_tag,
    input  mem_block_t               mem_data,
    input  mem_tag_t                 mem_data_tag,
    output mem_command_t             mem_command,
    output addr_t                    mem_addr,

    // fetch bundle
    output logic [`FETCH_WIDTH-1:0]  fetch_valid,
    output addr_t [`FETCH_WIDTH-1:0] fetch_pc,
    output inst_t [`FETCH_WIDTH-1:0] fetch_inst,
    output addr_t [`FETCH_WIDTH-1:0] fetch_npc,
    output logic [`FETCH_WIDTH-1:0]  fetch_predict_taken,
    output addr_t [`FETCH_WIDTH-1:0] fetch_predict_target
);

    addr_t pc_start;
    addr_t next_pc_start;
    logic  mispredict;
    logic  run_open;

    logic [`FETCH_WIDTH-1:0]       lane_valid;
    logic [`FETCH_WIDTH-1:0]       lane_taken;
    addr_t [`FETCH_WIDTH-1:0]      lane_next_pc;

    addr_t [`FETCH_WIDTH-1:0]      lookup_addr;
    logic [`FETCH_WIDTH-1:0]       lookup_valid;
    logic [`FETCH_WIDTH-1:0]       lookup_hit;
    mem_block_t [`FETCH_WIDTH-1:0] lookup_block;

    branch_predictor branch_predictor_i (
        .clock          (clock),
        .reset          (reset),
        .pc_start       (pc_start),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .lane_valid     (lane_valid),
        .lane_taken     (lane_taken),
        .lane_next_pc   (lane_next_pc)
    );

    icache icache_i (
        .clock               (clock),
        .reset               (reset),
        .stall               (stall),
        .lookup_addr         (lookup_addr),
        .lookup_valid        (lookup_valid),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag),
        .lookup_hit          (lookup_hit),
        .lookup_block        (lookup_block),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr)
    );

    assign mispredict = resolve_valid && resolve_mispredict;

    // sequential lane addresses; a redirect kills the whole bundle
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lookup_addr[i]  = pc_start + addr_t'(4 * i);
            lookup_valid[i] = lane_valid[i] && !mispredict;
        end
    end

    // deliver the leading run of valid lanes that hit
    always_comb begin
        run_open = 1'b1;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            fetch_valid[i] = run_open && lookup_valid[i] && lookup_hit[i];
            run_open       = fetch_valid[i];
            fetch_pc[i]    = lookup_addr[i];
            // bit 2 picks the instruction half of the block
            fetch_inst[i]  = fetch_valid[i] ? lookup_block[i].insts[lookup_addr[i][2]]
                                            : `NOP_INST;
            fetch_npc[i]            = lookup_addr[i] + 32'd4;
            fetch_predict_taken[i]  = lane_taken[i];
            fetch_predict_target[i] = lane_next_pc[i];
        end
    end

    // next fetch address: mispredict, then stall, then last delivered lane
    always_comb begin
        next_pc_start = pc_start;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (fetch_valid[i]) begin
                next_pc_start = lane_next_pc[i];
            end
        end
        if (stall) begin
            next_pc_start = pc_start;
        end
        if (mispredict) begin
            next_pc_start = resolve_target;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_start <= '0;
        end else begin
            pc_start <= next_pc_start;
        end
    end

endmodule

/* tb_memory_model.sv */
`timescale 1ns/10ps

module tb_memory_model import fetch_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  mem_command_t mem_command,
    input  addr_t        mem_addr,
    output mem_tag_t     mem_transaction_tag,
    output mem_block_t   mem_data,
    output mem_tag_t     mem_data_tag
);

    // cycles from the load strobe to the data
    localparam int          LATENCY = 4;
    localparam logic [31:0] SEED    = 32'hfaa8_0741;

    mem_tag_t next_tag;
    mem_tag_t flight_tag  [LATENCY];
    addr_t    flight_addr [LATENCY];

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // content is a pure function of the whole word address
    function automatic inst_t inst_at(input addr_t addr);
        return lcg_next(lcg_next(SEED ^ addr));
    endfunction

    // every load is accepted and tagged in the same cycle
    assign mem_transaction_tag = (mem_command == MEM_LOAD) ? next_tag : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= 4'h1;
            for (int k = 0; k < LATENCY; k++) begin
                flight_tag[k]  <= '0;
                flight_addr[k] <= '0;
            end
        end else begin
            if (mem_command == MEM_LOAD) begin
                // tag zero is reserved for no transaction
                next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
            end
            flight_tag[0]  <= mem_transaction_tag;
            flight_addr[0] <= mem_addr;
            for (int k = 1; k < LATENCY; k++) begin
                flight_tag[k]  <= flight_tag[k-1];
                flight_addr[k] <= flight_addr[k-1];
            end
        end
    end

    // lower word holds the instruction at the block address
    assign mem_data_tag = flight_tag[LATENCY-1];

    always_comb begin
        mem_data.double_word = {inst_at(flight_addr[LATENCY-1] + 32'd4),
                                inst_at(flight_addr[LATENCY-1])};
    end

endmodule

/* tb_stage_fetch.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module tb_stage_fetch import fetch_pkg::*; ();

    // six tests of at most about 500 cycles plus margin
    localparam int          TEST_COUNT     = 6;
    localparam int          TEST_CYCLES    = 500;
    localparam int          TIMEOUT_CYCLES = TEST_COUNT * TEST_CYCLES + 1000;
    localparam logic [31:0] SEED           = 32'hfaa8_0741;

    // resolve pc carried by redirects and never trained as taken
    localparam addr_t REDIRECT_PC   = 32'h0000_fff0;
    localparam addr_t BRANCH_PC     = 32'h0000_21c0;
    localparam addr_t BRANCH_TARGET = 32'h0000_32d0;

    logic  clock;
    logic  reset;
    logic  stall;
    logic  resolve_valid;
    addr_t resolve_pc;
    logic  resolve_taken;
    addr_t resolve_target;
    logic  resolve_mispredict;

    mem_tag_t     mem_transaction_tag;
    mem_block_t   mem_data;
    mem_tag_t     mem_data_tag;
    mem_command_t mem_command;
    addr_t        mem_addr;

    logic [`FETCH_WIDTH-1:0]  fetch_valid;
    addr_t [`FETCH_WIDTH-1:0] fetch_pc;
    inst_t [`FETCH_WIDTH-1:0] fetch_inst;
    addr_t [`FETCH_WIDTH-1:0] fetch_npc;
    logic [`FETCH_WIDTH-1:0]  fetch_predict_taken;
    addr_t [`FETCH_WIDTH-1:0] fetch_predict_target;

    // delivered lanes in order
    addr_t seen_pc     [$];
    inst_t seen_inst   [$];
    addr_t seen_npc    [$];
    logic  seen_taken  [$];
    addr_t seen_target [$];

    // addresses of the load strobes in order
    addr_t load_addr [$];

    int    addr_errors  = 0;
    int    inst_errors  = 0;
    int    bit_errors   = 0;
    int    other_errors = 0;
    int    load_count   = 0;
    int    cycle_count  = 0;
    addr_t expect_pc;

    stage_fetch stage_fetch_i (
        .clock                (clock),
        .reset                (reset),
        .stall                (stall),
        .resolve_valid        (resolve_valid),
        .resolve_pc           (resolve_pc),
        .resolve_taken        (resolve_taken),
        .resolve_target       (resolve_target),
        .resolve_mispredict   (resolve_mispredict),
        .mem_transaction_tag  (mem_transaction_tag),
        .mem_data             (mem_data),
        .mem_data_tag         (mem_data_tag),
        .mem_command          (mem_command),
        .mem_addr             (mem_addr),
        .fetch_valid          (fetch_valid),
        .fetch_pc             (fetch_pc),
        .fetch_inst           (fetch_inst),
        .fetch_npc            (fetch_npc),
        .fetch_predict_taken  (fetch_predict_taken),
        .fetch_predict_target (fetch_predict_target)
    );

    tb_memory_model memory_model_i (
        .clock               (clock),
        .reset               (reset),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag)
    );

    initial begin
        clock = 1'b0;
    end

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, tests still running after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // a held bundle under stall is not a delivery
    always @(posedge clock) begin
        if (!reset) begin
            if (mem_command == MEM_LOAD) begin
                load_count++;
                load_addr.push_back(mem_addr);
            end
            if (!stall) begin
                for (int i = 0; i < `FETCH_WIDTH; i++) begin
                    if (fetch_valid[i]) begin
                        seen_pc.push_back(fetch_pc[i]);
                        seen_inst.push_back(fetch_inst[i]);
                        seen_npc.push_back(fetch_npc[i]);
                        seen_taken.push_back(fetch_predict_taken[i]);
                        seen_target.push_back(fetch_predict_target[i]);
                    end
                end
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic inst_t inst_at(input addr_t addr);
        return lcg_next(lcg_next(SEED ^ addr));
    endfunction

    task automatic compare_addr(input string name, input addr_t actual, input addr_t expected);
        if (actual !== expected) begin
            addr_errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic compare_inst(input string name, input inst_t actual, input inst_t expected);
        if (actual !== expected) begin
            inst_errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            bit_errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic clear_seen();
        seen_pc.delete();
        seen_inst.delete();
        seen_npc.delete();
        seen_taken.delete();
        seen_target.delete();
    endtask

    // next delivered lane against the memory function and the prediction
    task automatic check_lane(input addr_t pc, input logic taken, input addr_t target);
        addr_t got_pc;
        inst_t got_inst;
        addr_t got_npc;
        logic  got_taken;
        addr_t got_target;
        while (seen_pc.size() == 0) begin
            @(negedge clock);
        end
        got_pc     = seen_pc.pop_front();
        got_inst   = seen_inst.pop_front();
        got_npc    = seen_npc.pop_front();
        got_taken  = seen_taken.pop_front();
        got_target = seen_target.pop_front();
        compare_addr("fetch_pc", got_pc, pc);
        compare_inst("fetch_inst", got_inst, inst_at(pc));
        compare_addr("fetch_npc", got_npc, pc + 32'd4);
        compare_bit("fetch_predict_taken", got_taken, taken);
        compare_addr("fetch_predict_target", got_target, target);
    endtask

    task automatic check_run(input int count);
        repeat (count) begin
            check_lane(expect_pc, 1'b0, expect_pc + 32'd4);
            expect_pc = expect_pc + 32'd4;
        end
    endtask

    task automatic train_branch(input addr_t pc, input logic taken, input addr_t target);
        @(negedge clock);
        resolve_valid      = 1'b1;
        resolve_pc         = pc;
        resolve_taken      = taken;
        resolve_target     = target;
        resolve_mispredict = 1'b0;
        @(negedge clock);
        resolve_valid = 1'b0;
    endtask

    // lanes seen before the redirect belong to the old path
    task automatic redirect_to(input addr_t target);
        @(negedge clock);
        clear_seen();
        resolve_valid      = 1'b1;
        resolve_pc         = REDIRECT_PC;
        resolve_taken      = 1'b0;
        resolve_target     = target;
        resolve_mispredict = 1'b1;
        @(negedge clock);
        resolve_valid      = 1'b0;
        resolve_mispredict = 1'b0;
        expect_pc          = target;
    endtask

    task automatic hold_stall(input int cycles);
        addr_t held;
        @(negedge clock);
        stall = 1'b1;
        @(negedge clock);
        // pc following the last lane delivered before the stall
        held = expect_pc + addr_t'(4 * seen_pc.size());
        repeat (cycles) begin
            @(negedge clock);
            compare_addr("fetch_pc[0] during stall", fetch_pc[0], held);
        end
        stall = 1'b0;
    endtask

    // cold misses load the blocks in order, one strobe each
    task automatic test_cold_fetch();
        expect_pc = '0;
        check_run(16);
        for (int k = 0; k < 8; k++) begin
            compare_addr("mem_addr", load_addr[k], addr_t'(8 * k));
        end
    endtask

    task automatic test_stall();
        hold_stall(10);
        check_run(8);
    endtask

    task automatic test_redirect();
        redirect_to(32'h0000_1080);
        check_run(8);
    endtask

    // lane at the branch ends its bundle and steers to the target
    task automatic test_taken_branch();
        train_branch(BRANCH_PC, 1'b1, BRANCH_TARGET);
        redirect_to(BRANCH_PC - 32'd8);
        check_run(2);
        check_lane(BRANCH_PC, 1'b1, BRANCH_TARGET);
        expect_pc = BRANCH_TARGET;
        check_run(4);
    endtask

    task automatic test_not_taken();
        train_branch(BRANCH_PC, 1'b0, BRANCH_PC + 32'd4);
        redirect_to(BRANCH_PC);
        check_run(4);
    endtask

    // region at zero was never evicted by the later regions
    task automatic test_cached_refetch();
        int loads_before;
        redirect_to('0);
        loads_before = load_count;
        check_run(16);
        if (load_count != loads_before) begin
            other_errors++;
            $display("cached re-fetch issued %0d memory loads, expected none",
                     load_count - loads_before);
        end
    endtask

    initial begin
        reset              = 1'b1;
        stall              = 1'b0;
        resolve_valid      = 1'b0;
        resolve_pc         = '0;
        resolve_taken      = 1'b0;
        resolve_target     = '0;
        resolve_mispredict = 1'b0;
        expect_pc          = '0;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        test_cold_fetch();
        test_stall();
        test_redirect();
        test_taken_branch();
        test_not_taken();
        test_cached_refetch();

        $display("errors: address %0d, instruction %0d, bit %0d, other %0d",
                 addr_errors, inst_errors, bit_errors, other_errors);
        if (addr_errors + inst_errors + bit_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
fetch_pkg.sv
branch_predictor.sv
icache.sv
stage_fetch.sv
tb_memory_model.sv
tb_stage_fetch.sv
